// File: board_params.svh
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// clock cycles per half period of the panel serial clock.
`define TM_BIT_DIV 4

// clock cycles per half period of the microphone sck.
`define I2S_SCK_DIV 4

// clock cycles between panel frame starts.
// a full frame has to fit inside this window.
`define REFRESH_CYCLES 2048

// width of one microphone sample.
`define SAMPLE_BITS 24

`endif

// File: board_pkg.sv
`include "board_params.svh"

package board_pkg;

    // one signed microphone sample.
    typedef logic signed [`SAMPLE_BITS - 1:0] sample_t;

    // seven-segment glyph, segment a in bit 0.
    typedef logic [7:0] seg_t;

    // panel LED and key vectors.
    typedef logic [7:0] led_t;
    typedef logic [7:0] key_t;

    // one byte on the panel serial link.
    typedef logic [7:0] tm_byte_t;

    // panel sequencer states.
    typedef enum logic [2:0]
    {
        idle,
        cmd_write,
        addr,
        data,
        cmd_ctrl,
        cmd_read,
        read_keys,
        gap
    } tm_state_t;

endpackage

// File: tick_gen.sv
`timescale 1ns/1ps
`include "board_params.svh"

module tick_gen
(
    input  logic clk,
    input  logic rst_n,
    output logic bit_tick,
    output logic sck_tick,
    output logic frame_tick
);

    // divisors in strobe order: bit, sck, frame.
    localparam int div [3] = '{`TM_BIT_DIV, `I2S_SCK_DIV, `REFRESH_CYCLES};

    // wide enough for the largest divisor.
    localparam int cnt_w = $clog2(`REFRESH_CYCLES + `TM_BIT_DIV + `I2S_SCK_DIV);

    for (genvar i = 0; i < 3; i++)
    begin : g_cnt
        logic [cnt_w - 1:0] cnt;
        logic               strobe;

        always_ff @(posedge clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                cnt    <= cnt_w'(div[i] - 1);
                strobe <= 1'b0;
            end
            else if (cnt == '0)
            begin
                cnt    <= cnt_w'(div[i] - 1);
                strobe <= 1'b1;
            end
            else
            begin
                cnt    <= cnt - cnt_w'(1);
                strobe <= 1'b0;
            end
        end
    end

    assign bit_tick   = g_cnt[0].strobe;
    assign sck_tick   = g_cnt[1].strobe;
    assign frame_tick = g_cnt[2].strobe;

endmodule

// File: i2s_mic_receiver.sv
`timescale 1ns/1ps
`include "board_params.svh"

module i2s_mic_receiver
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sck_tick,
    output logic               mic_sck,
    output logic               mic_ws,
    output logic               mic_lr,
    input  logic               mic_sd,
    output logic               sample_valid,
    output board_pkg::sample_t sample_data,
    input  logic               sample_ready
);

    // sck periods per ws slot.
    localparam int slot_bits = 32;
    localparam int cnt_w     = $clog2(slot_bits);

    logic [cnt_w - 1:0] bit_cnt;
    board_pkg::sample_t shift_q;
    logic               sck_rise;
    logic               sck_fall;
    logic               in_window;
    logic               last_bit;
    logic               shift_done;
    logic               load;

    // lr low puts the microphone on the left slot.
    assign mic_lr = 1'b0;

    assign sck_rise = sck_tick && !mic_sck;
    assign sck_fall = sck_tick && mic_sck;

    // msb arrives one sck after ws falls.
    assign in_window = !mic_ws && (bit_cnt != '0) && (bit_cnt <= cnt_w'(`SAMPLE_BITS));
    assign last_bit  = sck_rise && !mic_ws && (bit_cnt == cnt_w'(`SAMPLE_BITS));

    // new sample is dropped while the old one waits.
    assign load = shift_done && (!sample_valid || sample_ready);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mic_sck <= 1'b0;
            mic_ws  <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            if (sck_tick)
                mic_sck <= ~mic_sck;

            // ws and bit count move on the falling edge.
            if (sck_fall)
            begin
                bit_cnt <= bit_cnt + cnt_w'(1);
                if (bit_cnt == cnt_w'(slot_bits - 1))
                    mic_ws <= ~mic_ws;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sck_rise && in_window)
            shift_q <= {shift_q[`SAMPLE_BITS - 2:0], mic_sd};
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_done   <= 1'b0;
            sample_valid <= 1'b0;
        end
        else
        begin
            shift_done <= last_bit;
            if (load)
                sample_valid <= 1'b1;
            else if (sample_ready)
                sample_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
            sample_data <= shift_q;
    end

    // a stalled sample is held as offered.
    assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && !sample_ready |=> sample_valid && $stable(sample_data))
        else $error("sample_data changed while stalled");

endmodule

// File: display_formatter.sv
`timescale 1ns/1ps
`include "board_params.svh"

module display_formatter
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sample_valid,
    input  board_pkg::sample_t sample_data,
    output logic               sample_ready,
    input  board_pkg::key_t    key_data,
    output logic [63:0]        seg_data,
    output board_pkg::led_t    led_data
);

    localparam board_pkg::seg_t glyph_hold  = 8'h76;
    localparam board_pkg::seg_t glyph_blank = 8'h00;

    logic            hold;
    logic            key0_q;
    logic            key_rise;
    logic            accept;
    logic [47:0]     hex_q;
    logic [47:0]     hex_next;
    logic [7:0]      top;
    logic [7:0]      mag;
    logic [6:0]      level;
    board_pkg::led_t led_next;

    function automatic board_pkg::seg_t hex_glyph(input logic [3:0] nib);
        case (nib)
            4'h0:    return 8'h3F;
            4'h1:    return 8'h06;
            4'h2:    return 8'h5B;
            4'h3:    return 8'h4F;
            4'h4:    return 8'h66;
            4'h5:    return 8'h6D;
            4'h6:    return 8'h7D;
            4'h7:    return 8'h07;
            4'h8:    return 8'h7F;
            4'h9:    return 8'h6F;
            4'hA:    return 8'h77;
            4'hB:    return 8'h7C;
            4'hC:    return 8'h39;
            4'hD:    return 8'h5E;
            4'hE:    return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    assign sample_ready = !hold;
    assign accept       = sample_valid && sample_ready;
    assign key_rise     = key_data[0] && !key0_q;

    // digit 2 carries the top nibble.
    always_comb
    begin
        for (int k = 0; k < 6; k++)
            hex_next[8 * k +: 8] = hex_glyph(sample_data[4 * (5 - k) +: 4]);
    end

    // level bar from the top byte, magnitude capped at 127.
    assign top   = sample_data[`SAMPLE_BITS - 1 -: 8];
    assign mag   = top[7] ? (~top + 8'd1) : top;
    assign level = (mag > 8'd127) ? 7'd127 : mag[6:0];

    always_comb
    begin
        for (int i = 0; i < 8; i++)
            led_next[i] = int'(level) > 16 * i;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            key0_q <= 1'b0;
            hold   <= 1'b0;
        end
        else
        begin
            key0_q <= key_data[0];
            if (key_rise)
                hold <= ~hold;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hex_q    <= '0;
            led_data <= '0;
        end
        else if (accept)
        begin
            hex_q    <= hex_next;
            led_data <= led_next;
        end
    end

    assign seg_data = {hex_q, glyph_blank, hold ? glyph_hold : glyph_blank};

    // hold stays on until the next key press.
    assert property (@(posedge clk) disable iff (!rst_n)
        hold && !key_rise |=> !sample_ready)
        else $error("sample_ready high during hold");

endmodule

// File: tm1638_sequencer.sv
`timescale 1ns/1ps

module tm1638_sequencer
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            bit_tick,
    input  logic            frame_tick,
    input  logic [63:0]     seg_data,
    input  board_pkg::led_t led_data,
    output board_pkg::key_t key_data,
    output logic            tm_clk,
    output logic            tm_stb,
    output logic            tm_dio_out,
    output logic            tm_dio_oe,
    input  logic            tm_dio_in
);

    localparam board_pkg::tm_byte_t cmd_auto_write = 8'h40;
    localparam board_pkg::tm_byte_t cmd_addr_0     = 8'hC0;
    localparam board_pkg::tm_byte_t cmd_display_on = 8'h8F;
    localparam board_pkg::tm_byte_t cmd_key_read   = 8'h42;

    // two phases per bit, then one closing step.
    localparam logic [4:0] last_phase = 5'd16;

    board_pkg::tm_state_t state;
    board_pkg::tm_state_t ret_state;
    logic [4:0]           phase;
    logic [3:0]           byte_cnt;
    board_pkg::tm_byte_t  shift_q;
    board_pkg::key_t      key_acc;
    board_pkg::key_t      key_next;
    board_pkg::tm_byte_t  data_byte;
    logic [3:0]           data_idx;
    logic                 byte_end;
    logic                 frame_start;
    logic                 last_data;

    assign byte_end    = bit_tick && (phase == last_phase);
    assign frame_start = (state == board_pkg::idle) && frame_tick;
    assign last_data   = (state == board_pkg::data) && (byte_cnt == 4'd15);

    // even slots carry digits, odd slots one led each.
    always_comb
    begin
        data_idx = (state == board_pkg::data) ? byte_cnt + 4'd1 : 4'd0;
        if (data_idx[0])
            data_byte = {7'd0, led_data[data_idx[3:1]]};
        else
            data_byte = seg_data[8 * data_idx[3:1] +: 8];
    end

    // two keys per read byte, in bits 0 and 4.
    always_comb
    begin
        key_next = key_acc;
        key_next[{byte_cnt[1:0], 1'b0}] = shift_q[0];
        key_next[{byte_cnt[1:0], 1'b1}] = shift_q[4];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= board_pkg::idle;
            ret_state  <= board_pkg::idle;
            phase      <= '0;
            byte_cnt   <= '0;
            key_acc    <= '0;
            key_data   <= '0;
            tm_clk     <= 1'b1;
            tm_stb     <= 1'b1;
            tm_dio_out <= 1'b1;
            tm_dio_oe  <= 1'b0;
        end
        else if (state == board_pkg::idle)
        begin
            if (frame_tick)
            begin
                state     <= board_pkg::cmd_write;
                phase     <= '0;
                tm_stb    <= 1'b0;
                tm_dio_oe <= 1'b1;
            end
        end
        else if (state == board_pkg::gap)
        begin
            // strobe high for one bit step between commands.
            if (bit_tick)
            begin
                state     <= ret_state;
                phase     <= '0;
                tm_stb    <= 1'b0;
                tm_dio_oe <= 1'b1;
            end
        end
        else if (byte_end)
        begin
            phase <= '0;
            case (state)
                board_pkg::addr:
                begin
                    state    <= board_pkg::data;
                    byte_cnt <= '0;
                end
                board_pkg::data:
                begin
                    byte_cnt <= byte_cnt + 4'd1;
                    if (last_data)
                    begin
                        state     <= board_pkg::gap;
                        ret_state <= board_pkg::cmd_ctrl;
                        tm_stb    <= 1'b1;
                        tm_dio_oe <= 1'b0;
                    end
                end
                board_pkg::cmd_read:
                begin
                    state     <= board_pkg::read_keys;
                    byte_cnt  <= '0;
                    tm_dio_oe <= 1'b0;
                end
                board_pkg::read_keys:
                begin
                    key_acc  <= key_next;
                    byte_cnt <= byte_cnt + 4'd1;
                    if (byte_cnt == 4'd3)
                    begin
                        state    <= board_pkg::idle;
                        tm_stb   <= 1'b1;
                        key_data <= key_next;
                    end
                end
                default:
                begin
                    // cmd_write and cmd_ctrl close their strobe.
                    state     <= board_pkg::gap;
                    ret_state <= (state == board_pkg::cmd_write) ? board_pkg::addr
                                                                 : board_pkg::cmd_read;
                    tm_stb    <= 1'b1;
                    tm_dio_oe <= 1'b0;
                end
            endcase
        end
        else if (bit_tick)
        begin
            phase <= phase + 5'd1;
            if (!phase[0])
            begin
                tm_clk     <= 1'b0;
                tm_dio_out <= shift_q[0];
            end
            else
            begin
                tm_clk <= 1'b1;
            end
        end
    end

    // one register shifts bytes out and keys in, lsb first.
    always_ff @(posedge clk)
    begin
        if (frame_start)
            shift_q <= cmd_auto_write;
        else if (byte_end)
        begin
            case (state)
                board_pkg::cmd_write: shift_q <= cmd_addr_0;
                board_pkg::addr:      shift_q <= data_byte;
                board_pkg::data:      shift_q <= last_data ? cmd_display_on : data_byte;
                board_pkg::cmd_ctrl:  shift_q <= cmd_key_read;
                default:              shift_q <= shift_q;
            endcase
        end
        else if (bit_tick && phase[0])
            shift_q <= {tm_dio_in, shift_q[7:1]};
    end

    // panel may drive data only inside a strobe.
    assert property (@(posedge clk) disable iff (!rst_n)
        tm_stb |-> !tm_dio_oe)
        else $error("tm_dio_oe high with tm_stb high");

    // strobe only rises with the serial clock parked high.
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tm_stb) |-> $past(tm_clk))
        else $error("tm_stb rose with tm_clk low");

endmodule

// File: board_top.sv
`timescale 1ns/1ps

module board_top
(
    input  logic clk,
    input  logic rst_n,

    output logic mic_sck,
    output logic mic_ws,
    output logic mic_lr,
    input  logic mic_sd,

    output logic tm_clk,
    output logic tm_stb,
    output logic tm_dio_out,
    output logic tm_dio_oe,
    input  logic tm_dio_in
);

    logic               bit_tick;
    logic               sck_tick;
    logic               frame_tick;
    logic               sample_valid;
    logic               sample_ready;
    board_pkg::sample_t sample_data;
    board_pkg::key_t    key_data;
    logic [63:0]        seg_data;
    board_pkg::led_t    led_data;

    tick_gen i_tick_gen
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .bit_tick   ( bit_tick   ),
        .sck_tick   ( sck_tick   ),
        .frame_tick ( frame_tick )
    );

    i2s_mic_receiver i_microphone
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .sck_tick     ( sck_tick     ),
        .mic_sck      ( mic_sck      ),
        .mic_ws       ( mic_ws       ),
        .mic_lr       ( mic_lr       ),
        .mic_sd       ( mic_sd       ),
        .sample_valid ( sample_valid ),
        .sample_data  ( sample_data  ),
        .sample_ready ( sample_ready )
    );

    display_formatter i_formatter
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .sample_valid ( sample_valid ),
        .sample_data  ( sample_data  ),
        .sample_ready ( sample_ready ),
        .key_data     ( key_data     ),
        .seg_data     ( seg_data     ),
        .led_data     ( led_data     )
    );

    tm1638_sequencer i_tm1638
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .bit_tick   ( bit_tick   ),
        .frame_tick ( frame_tick ),
        .seg_data   ( seg_data   ),
        .led_data   ( led_data   ),
        .key_data   ( key_data   ),
        .tm_clk     ( tm_clk     ),
        .tm_stb     ( tm_stb     ),
        .tm_dio_out ( tm_dio_out ),
        .tm_dio_oe  ( tm_dio_oe  ),
        .tm_dio_in  ( tm_dio_in  )
    );

endmodule

// File: tb_board_top.sv
`timescale 1ns/1ps

module tb_board_top;

    localparam int frame_target = 40;
    localparam int cycle_limit  = 100000;
    localparam int hist_len     = 10;

    logic clk;
    logic rst_n;
    logic mic_sd;
    logic tm_dio_in;
    wire  mic_sck;
    wire  mic_ws;
    wire  mic_lr;
    wire  tm_clk;
    wire  tm_stb;
    wire  tm_dio_out;
    wire  tm_dio_oe;

    board_top u_dut
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .mic_sck    ( mic_sck    ),
        .mic_ws     ( mic_ws     ),
        .mic_lr     ( mic_lr     ),
        .mic_sd     ( mic_sd     ),
        .tm_clk     ( tm_clk     ),
        .tm_stb     ( tm_stb     ),
        .tm_dio_out ( tm_dio_out ),
        .tm_dio_oe  ( tm_dio_oe  ),
        .tm_dio_in  ( tm_dio_in  )
    );

    int          errors = 0;
    int          timeouts = 0;
    int          cycles = 0;
    int          frames = 0;
    int          hold_frames = 0;
    logic        resumed = 1'b0;
    logic [15:0] lfsr = 16'd53077;
    logic [23:0] shift_acc = '0;
    logic [23:0] hist [hist_len];
    int          mic_cnt = 0;
    int          ws_falls = 0;
    logic        prev_sck = 1'b0;
    logic        prev_ws = 1'b0;
    logic        prev_clk = 1'b1;
    logic        prev_stb = 1'b1;
    logic        rd_mode = 1'b0;
    int          bit_n = 0;
    int          byte_n = 0;
    int          stb_idx = 0;
    logic [7:0]  rx_byte = '0;
    logic [7:0]  first_byte = '0;
    logic [7:0]  mem [16];
    logic [7:0]  held [16];
    logic [7:0]  key_frame = '0;
    logic [7:0]  key_out = '0;
    logic        prev_key0 = 1'b0;
    logic        hold_exp = 1'b0;
    logic        hold_frame = 1'b0;
    logic        hold_prev = 1'b0;

    // one-cycle check strobes from the models, sampled by the assertions.
    logic        frame_seen = 1'b0;
    logic        ws_check = 1'b0;
    logic        ws_ok = 1'b1;
    int          ws_period = 0;
    logic        oe_check = 1'b0;
    logic        oe_ok = 1'b1;
    logic        strobe_check = 1'b0;
    logic        strobe_ok = 1'b1;
    logic [31:0] strobe_exp = '0;
    logic [31:0] strobe_got = '0;
    logic        disp_check = 1'b0;
    logic        disp_ok = 1'b1;
    string       disp_name = "";
    logic [31:0] disp_exp = '0;
    logic [31:0] disp_got = '0;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [7:0] glyph(input logic [3:0] nib);
        logic [7:0] table_q [16];
        table_q = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
                    8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71};
        return table_q[nib];
    endfunction

    // led i is lit when the clipped magnitude of the top byte exceeds 16 i.
    function automatic logic led_lit(input logic [23:0] s, input int i);
        int m;
        m = int'($signed(s[23:16]));
        if (m < 0)
            m = -m;
        if (m > 127)
            m = 127;
        return m > 16 * i;
    endfunction

    // key 2b in bit 0, key 2b+1 in bit 4.
    function automatic logic [7:0] key_byte(input logic [7:0] keys, input int b);
        return {3'b000, keys[2 * b + 1], 3'b000, keys[2 * b]};
    endfunction

    // key 0 held over two reads for each press.
    function automatic logic [7:0] key_script(input int f);
        return (f == 10 || f == 11 || f == 24 || f == 25) ? 8'h01 : 8'h00;
    endfunction

    task automatic note_error(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
        errors++;
        $display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic flag_display(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        if (disp_ok)
        begin
            disp_name = name;
            disp_exp  = exp;
            disp_got  = got;
        end
        disp_ok = 1'b0;
    endtask

    task automatic check_frame();
        logic found;
        disp_ok    = 1'b1;
        disp_check = 1'b1;
        if (mem[2] != 8'h00)
            flag_display("digit 1", 32'h00, 32'(mem[2]));
        if (hold_frame)
        begin
            hold_frames++;
            if (mem[0] != 8'h76)
                flag_display("digit 0", 32'h76, 32'(mem[0]));
            for (int d = 2; d < 8; d++)
                if (hold_prev && mem[2 * d] != held[2 * d])
                    flag_display($sformatf("held digit %0d", d), 32'(held[2 * d]),
                                 32'(mem[2 * d]));
        end
        else
        begin
            if (mem[0] != 8'h00)
                flag_display("digit 0", 32'h00, 32'(mem[0]));
            if (!hold_prev && frames > 0)
            begin
                if (hold_frames > 0)
                    resumed = 1'b1;
                for (int d = 2; d < 8; d++)
                begin
                    found = 1'b0;
                    for (int h = 0; h < hist_len; h++)
                        if (glyph(hist[h][4 * (7 - d) +: 4]) == mem[2 * d])
                            found = 1'b1;
                    if (!found)
                        flag_display($sformatf("digit %0d", d),
                                     32'(glyph(hist[0][4 * (7 - d) +: 4])), 32'(mem[2 * d]));
                end
                for (int i = 0; i < 8; i++)
                begin
                    found = 1'b0;
                    for (int h = 0; h < hist_len; h++)
                        if ({7'd0, led_lit(hist[h], i)} == mem[2 * i + 1])
                            found = 1'b1;
                    if (!found)
                        flag_display($sformatf("led %0d", i), 32'(led_lit(hist[0], i)),
                                     32'(mem[2 * i + 1]));
                end
            end
        end
        if (key_frame[0] && !prev_key0)
            hold_exp = !hold_exp;
        prev_key0 = key_frame[0];
        hold_prev = hold_frame;
        held      = mem;
        frames++;
    endtask

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    always @(posedge clk)
        cycles++;

    // microphone and panel models, acting just after each clock edge.
    always @(posedge clk)
    begin
        #10;
        ws_check     = 1'b0;
        oe_check     = 1'b0;
        strobe_check = 1'b0;
        disp_check   = 1'b0;
        if (rst_n && prev_sck && !mic_sck)
        begin
            ws_falls++;
            if (mic_ws != prev_ws)
            begin
                ws_check  = 1'b1;
                ws_ok     = ws_falls == 32;
                ws_period = ws_falls;
                ws_falls  = 0;
                mic_cnt   = 0;
            end
            else
                mic_cnt++;
            if (!mic_ws && mic_cnt >= 1 && mic_cnt <= 24)
            begin
                mic_sd    = lfsr[0];
                shift_acc = {shift_acc[22:0], lfsr[0]};
                lfsr      = lfsr_next(lfsr);
                if (mic_cnt == 24)
                begin
                    for (int h = hist_len - 1; h > 0; h--)
                        hist[h] = hist[h - 1];
                    hist[0] = shift_acc;
                end
            end
        end
        if (rst_n && prev_stb && !tm_stb)
        begin
            bit_n      = 0;
            byte_n     = 0;
            rd_mode    = 1'b0;
            first_byte = '0;
            if (stb_idx == 0)
            begin
                frame_seen = 1'b1;
                hold_frame = hold_exp;
                key_frame  = key_script(frames);
            end
        end
        if (!tm_stb && prev_clk && !tm_clk && rd_mode)
        begin
            key_out   = key_byte(key_frame, byte_n - 1);
            tm_dio_in = key_out[bit_n];
        end
        if (!tm_stb && !prev_clk && tm_clk)
        begin
            oe_check = 1'b1;
            oe_ok    = tm_dio_oe == !rd_mode;
            rx_byte  = {tm_dio_out, rx_byte[7:1]};
            bit_n++;
            if (bit_n == 8)
            begin
                bit_n = 0;
                if (!rd_mode)
                begin
                    if (byte_n == 0)
                        first_byte = rx_byte;
                    else if (stb_idx == 1 && byte_n <= 16)
                        mem[byte_n - 1] = rx_byte;
                    rd_mode = first_byte == 8'h42;
                end
                byte_n++;
            end
        end
        if (rst_n && !prev_stb && tm_stb)
        begin
            strobe_check = 1'b1;
            case (stb_idx)
                0:       strobe_exp = {8'h40, 24'd1};
                1:       strobe_exp = {8'hC0, 24'd17};
                2:       strobe_exp = {8'h8F, 24'd1};
                default: strobe_exp = {8'h42, 24'd5};
            endcase
            strobe_got = {first_byte, 24'(byte_n)};
            strobe_ok  = strobe_got == strobe_exp && bit_n == 0;
            if (stb_idx == 3)
            begin
                stb_idx = 0;
                check_frame();
            end
            else
                stb_idx++;
        end
        prev_sck = mic_sck;
        prev_ws  = mic_ws;
        prev_clk = tm_clk;
        prev_stb = tm_stb;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !frame_seen |-> tm_stb && tm_clk && !tm_dio_oe)
        else
        begin
            errors++;
            $display("panel lines left their idle levels before the first frame at %0t",
                     $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) !mic_lr)
        else note_error("mic_lr", 32'd0, 32'd1);

    assert property (@(posedge clk) ws_check |-> ws_ok)
        else note_error("mic_ws period", 32'd32, 32'(ws_period));

    assert property (@(posedge clk) oe_check |-> oe_ok)
        else note_error("tm_dio_oe", 32'(!rd_mode), 32'(tm_dio_oe));

    // byte value in the top byte, byte count below it.
    assert property (@(posedge clk) strobe_check |-> strobe_ok)
        else note_error("tm_dio_out strobe", strobe_exp, strobe_got);

    assert property (@(posedge clk) disp_check |-> disp_ok)
        else note_error(disp_name, disp_exp, disp_got);

    initial
    begin
        rst_n     = 1'b0;
        mic_sd    = 1'b0;
        tm_dio_in = 1'b1;
        for (int h = 0; h < hist_len; h++)
            hist[h] = '0;
        for (int k = 0; k < 16; k++)
        begin
            mem[k]  = '0;
            held[k] = '0;
        end
        repeat (16) @(posedge clk);
        #10 rst_n = 1'b1;
        while (frames < frame_target && cycles < cycle_limit)
            @(posedge clk);
        if (frames < frame_target)
        begin
            timeouts = 1;
            $display("timeout after %0d cycles with %0d of %0d frames done",
                     cycles, frames, frame_target);
        end
        if (hold_frames == 0 || !resumed)
        begin
            errors++;
            $display("hold mode was not entered and then left as the key script expects");
        end
        $display("summary: %0d check errors, %0d timeouts, %0d frames", errors, timeouts,
                 frames);
        if (errors == 0 && timeouts == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: project.f
+incdir+.
board_pkg.sv
tick_gen.sv
i2s_mic_receiver.sv
display_formatter.sv
tm1638_sequencer.sv
board_top.sv
tb_board_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_board_top
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

SOURCES := $(wildcard *.sv) $(wildcard *.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
